//--- hw/mapper_pkg.sv
package mapper_pkg;

	//////////////////////////////////////////////////
	// cpu side geometry
	//////////////////////////////////////////////////

	// 16-bit z80 address, four 16k windows
	localparam int CPU_ADDR_W  = 16;
	localparam int NUM_WINDOWS = 4;
	localparam int WIN_SEL_W   = 2;
	localparam int WIN_OFS_W   = 14;

	//////////////////////////////////////////////////
	// physical side geometry
	//////////////////////////////////////////////////

	// 128 pages of 16k give 2M of ram
	localparam int RAM_PAGE_W = 7;
	localparam int ROM_BANK_W = 4;

	// bank on top, dos flag in bit 0
	localparam int ROM_PAGE_W = ROM_BANK_W + 1;

	// page on top, window offset below
	localparam int PHYS_W = RAM_PAGE_W + WIN_OFS_W;

	//////////////////////////////////////////////////
	// port and trap addresses
	//////////////////////////////////////////////////

	// low address byte of the pager port
	localparam logic [7:0] PAGER_PORT_DEF = 8'hF7;

	// opcode fetch from 3Dxx enters dos
	localparam logic [7:0] DOS_TRAP_HI = 8'h3D;

	//////////////////////////////////////////////////
	// window word
	//////////////////////////////////////////////////

	// bit 7 tells ram from rom, the rest is read per view
	typedef union packed {
		struct packed {
			logic                  is_rom;
			logic [RAM_PAGE_W-1:0] page;
		} ram;
		struct packed {
			logic                  is_rom;
			logic [2:0]            unused;
			logic [ROM_BANK_W-1:0] bank;
		} rom;
	} window_word_u;

	// power-up layout, like a 128k machine after reset
	// window 3 is leftmost
	localparam window_word_u [NUM_WINDOWS-1:0] RESET_WORDS = {
		8'h00,  // window 3, ram page 0
		8'h02,  // window 2, ram page 2
		8'h05,  // window 1, ram page 5 (screen)
		8'h80   // window 0, rom bank 0
	};

endpackage

//--- hw/window_if.sv
`timescale 1ns/1ps

interface window_if
	import mapper_pkg::*;
();

	// current word of every cpu window
	window_word_u [NUM_WINDOWS-1:0] win_word;

	// dos half of the rom is selected
	logic dos;

	// pager registers own the window words
	modport regs (
		output win_word
	);

	// dos controller watches window 0 and owns the flag
	modport dos_ctl (
		input  win_word,
		output dos
	);

	// the mapper only consumes
	modport mapper (
		input win_word,
		input dos
	);

endinterface

//--- hw/page_regs.sv
`timescale 1ns/1ps

module page_regs
	import mapper_pkg::*;
#(
	parameter logic [7:0] PAGER_PORT = PAGER_PORT_DEF
)
(
	input  logic                  fclk,
	input  logic                  rst_n,

	input  logic                  port_wr,
	input  logic [CPU_ADDR_W-1:0] port_addr,
	input  logic [7:0]            port_data,

	window_if.regs                win
);

	//////////////////////////////////////////////////
	// pager port decode
	//////////////////////////////////////////////////

	logic                 pager_hit;
	logic [WIN_SEL_W-1:0] wr_sel;

	// only the low byte names the port
	assign pager_hit = port_wr && (port_addr[7:0] == PAGER_PORT);

	// high byte picks the window, its top two bits are enough
	assign wr_sel = port_addr[CPU_ADDR_W-1 -: WIN_SEL_W];

	//////////////////////////////////////////////////
	// window registers
	//////////////////////////////////////////////////

	window_word_u [NUM_WINDOWS-1:0] words_q;

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			words_q <= RESET_WORDS;
		end
		else if (pager_hit)
		begin
			// the whole byte is kept, unused rom bits included
			words_q[wr_sel] <= port_data;
		end
	end

	// new word is seen from the next edge on
	assign win.win_word = words_q;

endmodule

//--- hw/dos_ctrl.sv
`timescale 1ns/1ps

module dos_ctrl
	import mapper_pkg::*;
(
	input  logic                  fclk,
	input  logic                  rst_n,

	input  logic                  mem_req,
	input  logic                  mem_m1,
	input  logic [CPU_ADDR_W-1:0] mem_addr,

	window_if.dos_ctl             win
);

	//////////////////////////////////////////////////
	// fetch classification
	//////////////////////////////////////////////////

	logic fetch;
	logic trap_hit;
	logic leave_hit;

	// only opcode fetches move the flag
	assign fetch = mem_req && mem_m1;

	// 3Dxx counts only while window 0 is mapped to rom
	assign trap_hit = (mem_addr[CPU_ADDR_W-1 -: 8] == DOS_TRAP_HI)
		&& win.win_word[0].rom.is_rom;

	// anything outside window 0, i.e. 4000h and up
	assign leave_hit = (mem_addr[CPU_ADDR_W-1 -: WIN_SEL_W] != '0);

	//////////////////////////////////////////////////
	// dos flag
	//////////////////////////////////////////////////

	logic dos_q;
	logic dos_d;

	always_comb
	begin
		dos_d = dos_q;
		if (fetch && trap_hit)
			dos_d = 1'b1;
		else if (fetch && leave_hit)
			dos_d = 1'b0;
	end

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			dos_q <= 1'b0;
		else
			dos_q <= dos_d;
	end

	// the fetch itself still maps with the old flag
	assign win.dos = dos_q;

endmodule

//--- hw/addr_mapper.sv
`timescale 1ns/1ps

module addr_mapper
	import mapper_pkg::*;
(
	input  logic                  fclk,
	input  logic                  rst_n,

	input  logic                  mem_req,
	input  logic [CPU_ADDR_W-1:0] mem_addr,

	window_if.mapper              win,

	output logic                  map_valid,
	output logic                  csrom,
	output logic [ROM_PAGE_W-1:0] rom_page,
	output logic [PHYS_W-1:0]     ram_addr
);

	//////////////////////////////////////////////////
	// window select
	//////////////////////////////////////////////////

	logic [WIN_SEL_W-1:0] win_sel;
	logic [WIN_OFS_W-1:0] win_ofs;
	window_word_u         word;

	assign win_sel = mem_addr[CPU_ADDR_W-1 -: WIN_SEL_W];
	assign win_ofs = mem_addr[WIN_OFS_W-1:0];

	// words as they stood before this edge
	assign word = win.win_word[win_sel];

	//////////////////////////////////////////////////
	// control outputs
	//////////////////////////////////////////////////

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			map_valid <= 1'b0;
			csrom     <= 1'b0;
		end
		else
		begin
			map_valid <= mem_req;
			if (mem_req)
				csrom <= word.rom.is_rom;
		end
	end

	//////////////////////////////////////////////////
	// address outputs
	//////////////////////////////////////////////////

	// only the side that is hit gets loaded
	always_ff @(posedge fclk)
	begin
		if (mem_req)
		begin
			if (word.rom.is_rom)
			begin
				// dos picks the 48k basic or the trdos half
				rom_page <= {word.rom.bank, win.dos};
			end
			else
			begin
				ram_addr <= {word.ram.page, win_ofs};
			end
		end
	end

endmodule

//--- hw/zmap_top.sv
`timescale 1ns/1ps

module zmap_top
	import mapper_pkg::*;
#(
	parameter logic [7:0] PAGER_PORT = PAGER_PORT_DEF
)
(
	input  logic                  fclk,
	input  logic                  rst_n,

	// pager port writes
	input  logic                  port_wr,
	input  logic [CPU_ADDR_W-1:0] port_addr,
	input  logic [7:0]            port_data,

	// cpu memory requests
	input  logic                  mem_req,
	input  logic [CPU_ADDR_W-1:0] mem_addr,
	input  logic                  mem_m1,

	// mapped result
	output logic                  map_valid,
	output logic                  csrom,
	output logic [ROM_PAGE_W-1:0] rom_page,
	output logic [PHYS_W-1:0]     ram_addr,
	output logic                  dos
);

	// window words and dos flag between the blocks
	window_if win_bus ();

	//////////////////////////////////////////////////
	// page registers
	//////////////////////////////////////////////////

	page_regs #(
		.PAGER_PORT(PAGER_PORT)
	) u_page_regs (
		.fclk     (fclk),
		.rst_n    (rst_n),
		.port_wr  (port_wr),
		.port_addr(port_addr),
		.port_data(port_data),
		.win      (win_bus.regs)
	);

	//////////////////////////////////////////////////
	// dos controller
	//////////////////////////////////////////////////

	dos_ctrl u_dos_ctrl (
		.fclk    (fclk),
		.rst_n   (rst_n),
		.mem_req (mem_req),
		.mem_m1  (mem_m1),
		.mem_addr(mem_addr),
		.win     (win_bus.dos_ctl)
	);

	//////////////////////////////////////////////////
	// address mapper
	//////////////////////////////////////////////////

	addr_mapper u_addr_mapper (
		.fclk     (fclk),
		.rst_n    (rst_n),
		.mem_req  (mem_req),
		.mem_addr (mem_addr),
		.win      (win_bus.mapper),
		.map_valid(map_valid),
		.csrom    (csrom),
		.rom_page (rom_page),
		.ram_addr (ram_addr)
	);

	// flag is visible outside for the rom select pin
	assign dos = win_bus.dos;

endmodule

//--- verification/zmap_asserts.sv
`timescale 1ns/1ps

module zmap_asserts
(
	input logic fclk,
	input logic rst_n,
	input logic mem_req,
	input logic mem_m1,
	input logic map_valid,
	input logic csrom,
	input logic dos
);

	// read by the testbench when the run ends
	int fail_count = 0;

	// result strobe is the request one cycle later
	a_valid_latency: assert property (@(posedge fclk) disable iff (!rst_n)
		map_valid == $past(mem_req))
	else
	begin
		$error("map_valid is not mem_req delayed by one cycle");
		fail_count++;
	end

	a_reset_quiet: assert property (@(posedge fclk)
		!rst_n |-> (!map_valid && !csrom && !dos))
	else
	begin
		$error("map_valid, csrom or dos is set while rst_n is low");
		fail_count++;
	end

	// dos only moves after an opcode fetch
	a_dos_after_fetch: assert property (@(posedge fclk) disable iff (!rst_n)
		(dos != $past(dos)) |-> $past(mem_req && mem_m1))
	else
	begin
		$error("dos changed without an opcode fetch in the cycle before");
		fail_count++;
	end

endmodule

bind zmap_top zmap_asserts u_asserts (
	.fclk     (fclk),
	.rst_n    (rst_n),
	.mem_req  (mem_req),
	.mem_m1   (mem_m1),
	.map_valid(map_valid),
	.csrom    (csrom),
	.dos      (dos)
);

//--- verification/zmap_tb.sv
`timescale 1ns/1ps

module zmap_tb
	import mapper_pkg::*;
();

	localparam int N_WRITES  = 24;
	localparam int N_FOREIGN = 16;
	localparam int N_DOS     = 12;
	localparam int N_MIXED   = 400;
	// reset, reset map, one write plus four reads per group, dos, mixed, idle
	localparam int STIM_CYCLES = 2 + 4 + 5 * (N_WRITES + N_FOREIGN) + N_DOS + N_MIXED + 1;

	logic                  fclk;
	logic                  rst_n;
	logic                  port_wr;
	logic [15:0]           port_addr;
	logic [7:0]            port_data;
	logic                  mem_req;
	logic [15:0]           mem_addr;
	logic                  mem_m1;
	logic                  map_valid;
	logic                  csrom;
	logic [ROM_PAGE_W-1:0] rom_page;
	logic [PHYS_W-1:0]     ram_addr;
	logic                  dos;

	// reference state
	window_word_u model_words [NUM_WINDOWS];
	logic         model_dos;

	integer seed;
	int     errors;
	string  test_name;

	zmap_top #(.PAGER_PORT(PAGER_PORT_DEF)) DUT (.*);

	always #50 fclk = ~fclk;

	//////////////////////////////////////////////////
	// compare tasks
	//////////////////////////////////////////////////

	task automatic check_rom(input string name, input logic [ROM_PAGE_W-1:0] expected,
		input logic cs, input logic [ROM_PAGE_W-1:0] actual);
		if (cs !== 1'b1 || actual !== expected)
		begin
			$display("Error %s rom: expected cs 1 page %h, actual cs %b page %h",
				name, expected, cs, actual);
			errors++;
		end
	endtask

	task automatic check_ram(input string name, input logic [PHYS_W-1:0] expected,
		input logic cs, input logic [PHYS_W-1:0] actual);
		if (cs !== 1'b0 || actual !== expected)
		begin
			$display("Error %s ram: expected cs 0 addr %h, actual cs %b addr %h",
				name, expected, cs, actual);
			errors++;
		end
	endtask

	task automatic check_dos(input string name, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			$display("Error %s dos: expected %b, actual %b", name, expected, actual);
			errors++;
		end
	endtask

	// one edge of stimulus, entered and left 5 ns after a rising edge
	task automatic run_cycle(input logic wr, input logic [15:0] paddr,
		input logic [7:0] pdata, input logic req, input logic [15:0] maddr, input logic m1);
		window_word_u w;
		logic [ROM_PAGE_W-1:0] exp_page;
		logic [PHYS_W-1:0] exp_addr;
		port_wr   = wr;
		port_addr = paddr;
		port_data = pdata;
		mem_req   = req;
		mem_addr  = maddr;
		mem_m1    = m1;
		// result from the state before the edge
		w        = model_words[maddr[15:14]];
		exp_page = {w.rom.bank, model_dos};
		exp_addr = {w.ram.page, maddr[13:0]};
		if (req && m1)
		begin
			if (maddr[15:8] == DOS_TRAP_HI && model_words[0].rom.is_rom)
				model_dos = 1'b1;
			else if (maddr >= 16'h4000)
				model_dos = 1'b0;
		end
		if (wr && paddr[7:0] == PAGER_PORT_DEF)
			model_words[paddr[15:14]] = pdata;
		@(posedge fclk);
		#5;
		if (req && map_valid !== 1'b1)
		begin
			$display("%s: no map_valid one cycle after request at %h", test_name, maddr);
			errors++;
		end
		else if (!req && map_valid !== 1'b0)
		begin
			$display("%s: map_valid set without a request", test_name);
			errors++;
		end
		if (req && map_valid === 1'b1)
		begin
			if (w.rom.is_rom)
				check_rom(test_name, exp_page, csrom, rom_page);
			else
				check_ram(test_name, exp_addr, csrom, ram_addr);
		end
		check_dos(test_name, model_dos, dos);
	endtask

	//////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////

	initial
	begin
		logic [31:0] r;
		logic [31:0] q;
		seed = 32'h7f22;
		errors = 0;
		fclk = 1'b0;
		rst_n = 1'b1;
		port_wr = 1'b0;
		port_addr = '0;
		port_data = '0;
		mem_req = 1'b0;
		mem_addr = '0;
		mem_m1 = 1'b0;
		model_words[0] = 8'h80;
		model_words[1] = 8'h05;
		model_words[2] = 8'h02;
		model_words[3] = 8'h00;
		model_dos = 1'b0;
		// clean falling edge for the async reset
		#1 rst_n = 1'b0;
		repeat (2) @(posedge fclk);
		#5 rst_n = 1'b1;

		test_name = "reset_map";
		for (int w = 0; w < NUM_WINDOWS; w++)
		begin
			r = $random(seed);
			run_cycle(0, 0, 0, 1, {w[1:0], r[13:0]}, 0);
		end

		test_name = "page_writes";
		for (int i = 0; i < N_WRITES; i++)
		begin
			r = $random(seed);
			run_cycle(1, {r[15:8], PAGER_PORT_DEF}, r[23:16], 0, 0, 0);
			for (int w = 0; w < NUM_WINDOWS; w++)
			begin
				q = $random(seed);
				run_cycle(0, 0, 0, 1, {w[1:0], q[13:0]}, 0);
			end
		end

		test_name = "foreign_ports";
		for (int i = 0; i < N_FOREIGN; i++)
		begin
			r = $random(seed);
			if (r[7:0] == PAGER_PORT_DEF)
				r[0] = ~r[0];
			run_cycle(1, r[15:0], r[23:16], 0, 0, 0);
			for (int w = 0; w < NUM_WINDOWS; w++)
			begin
				q = $random(seed);
				run_cycle(0, 0, 0, 1, {w[1:0], q[13:0]}, 0);
			end
		end

		test_name = "dos_entry";
		r = $random(seed);
		run_cycle(1, 16'h00F7, 8'h83, 0, 0, 0);
		run_cycle(0, 0, 0, 1, {8'h3D, r[7:0]}, 1);
		run_cycle(0, 0, 0, 1, {2'b00, r[21:8]}, 0);
		test_name = "dos_exit";
		run_cycle(0, 0, 0, 1, {2'b10, r[13:0]}, 1);
		test_name = "dos_hold";
		run_cycle(0, 0, 0, 1, {8'h3D, r[15:8]}, 0);
		run_cycle(0, 0, 0, 1, {8'h3D, r[23:16]}, 1);
		run_cycle(1, 16'h00F7, 8'h04, 0, 0, 0);
		run_cycle(0, 0, 0, 1, {8'h3D, r[31:24]}, 1);
		run_cycle(0, 0, 0, 1, 16'h1234, 1);
		run_cycle(0, 0, 0, 1, {2'b01, r[13:0]}, 1);
		run_cycle(0, 0, 0, 1, {8'h3D, r[7:0]}, 1);
		run_cycle(1, 16'h00F7, 8'h80, 0, 0, 0);

		// requests and writes land on the same edges
		test_name = "back_to_back";
		for (int i = 0; i < N_MIXED; i++)
		begin
			r = $random(seed);
			q = $random(seed);
			run_cycle(r[0], {r[23:16], r[1] ? PAGER_PORT_DEF : r[15:8]}, r[31:24],
				q[0] | q[1], q[2] ? {8'h3D, q[15:8]} : q[31:16], q[3]);
		end

		test_name = "idle";
		run_cycle(0, 0, 0, 0, 0, 0);

		$display("checks failed: %0d, assertions failed: %0d", errors, DUT.u_asserts.fail_count);
		if (errors == 0 && DUT.u_asserts.fail_count == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

	// watchdog
	initial
	begin
		#(STIM_CYCLES * 100 * 2 + 1000);
		$display("watchdog expired before the test sequence completed");
		$display("TESTS FAILED");
		$finish;
	end

endmodule

//--- all.f
hw/mapper_pkg.sv
hw/window_if.sv
hw/page_regs.sv
hw/dos_ctrl.sv
hw/addr_mapper.sv
hw/zmap_top.sv
verification/zmap_asserts.sv
verification/zmap_tb.sv

//--- Bender.yml
package:
  name: zmap

sources:
  - hw/mapper_pkg.sv
  - hw/window_if.sv
  - hw/page_regs.sv
  - hw/dos_ctrl.sv
  - hw/addr_mapper.sv
  - hw/zmap_top.sv
  - target: test
    files:
      - verification/zmap_asserts.sv
      - verification/zmap_tb.sv
